//--- common/fifo_defs.svh
/*
 * Default widths and depth of the asymmetric FIFO.
 * Included by the package and by modules that take their parameter defaults from it.
 */
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// narrow write side
`define FIFO_W_DATA_W 8
// wide read side, a power-of-two multiple of the write width
`define FIFO_R_DATA_W 32
// capacity exponent in narrow units
`define FIFO_ADDR_W 6

`endif

//--- common/fifo_pkg.sv
/*
 * Shared types of the FIFO: RAM access structs and the per-cycle operation.
 * Referenced with scoped names by the FIFO, the RAM and the checker.
 */
`include "fifo_defs.svh"

package fifo_pkg;

   localparam int RATIO = `FIFO_R_DATA_W / `FIFO_W_DATA_W;
   localparam int RATIO_W = $clog2(RATIO);
   // RAM is addressed in wide words
   localparam int MEM_ADDR_W = `FIFO_ADDR_W - RATIO_W;

   typedef struct packed {
      logic                      en;
      logic [MEM_ADDR_W-1:0]     addr;
      logic [`FIFO_R_DATA_W-1:0] data;
      logic [RATIO-1:0]          strb;
   } mem_wr_t;

   typedef struct packed {
      logic                  en;
      logic [MEM_ADDR_W-1:0] addr;
   } mem_rd_t;

   // accepted operations in one cycle, bit 0 write and bit 1 read
   typedef enum logic [1:0] {
      OP_IDLE  = 2'b00,
      OP_WRITE = 2'b01,
      OP_READ  = 2'b10,
      OP_BOTH  = 2'b11
   } fifo_op_e;

endpackage

//--- source/dp_ram.sv
/*
 * Simple dual-port RAM, one write port with lane strobes and one registered read port.
 * Read data updates only on a read enable and holds otherwise.
 */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module dp_ram #(
   parameter int DATA_W = `FIFO_R_DATA_W,
   parameter int ADDR_W = fifo_pkg::MEM_ADDR_W,
   parameter int LANES  = fifo_pkg::RATIO
) (
   input  logic              clk_i,
   input  fifo_pkg::mem_wr_t wr_i,
   input  fifo_pkg::mem_rd_t rd_i,
   output logic [DATA_W-1:0] rdata_o
);

   localparam int LANE_W = DATA_W / LANES;
   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk_i) begin
      if (wr_i.en) begin
         for (int i = 0; i < LANES; i++) begin
            if (wr_i.strb[i]) begin
               mem[wr_i.addr][i*LANE_W +: LANE_W] <= wr_i.data[i*LANE_W +: LANE_W];
            end
         end
      end
   end

   // one cycle read latency
   always_ff @(posedge clk_i) begin
      if (rd_i.en) begin
         rdata_o <= mem[rd_i.addr];
      end
   end

endmodule

//--- fifo_sync/asym_converter.sv
/*
 * Maps narrow FIFO writes onto byte lanes of the wide RAM and addresses whole words on read.
 * Lane 0 of each word holds the earliest byte written to it.
 */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module asym_converter #(
   parameter int W_DATA_W = `FIFO_W_DATA_W,
   parameter int R_DATA_W = `FIFO_R_DATA_W,
   parameter int ADDR_W   = `FIFO_ADDR_W
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                w_en_i,
   input  logic [ADDR_W-1:0]   w_addr_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   input  logic                r_en_i,
   input  logic [ADDR_W-1:0]   r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output fifo_pkg::mem_wr_t   mem_wr_o,
   output fifo_pkg::mem_rd_t   mem_rd_o,
   input  logic [R_DATA_W-1:0] mem_rdata_i
);

   localparam int RATIO = R_DATA_W / W_DATA_W;
   localparam int RATIO_W = $clog2(RATIO);

   logic [RATIO_W-1:0]  w_lane;
   logic                r_vld_q;
   logic [R_DATA_W-1:0] r_hold_q;

   // low address bits pick the lane, the rest the word
   assign w_lane = w_addr_i[RATIO_W-1:0];

   always_comb begin
      mem_wr_o.en           = w_en_i;
      mem_wr_o.addr         = w_addr_i[ADDR_W-1:RATIO_W];
      mem_wr_o.data         = {RATIO{w_data_i}};
      mem_wr_o.strb         = '0;
      mem_wr_o.strb[w_lane] = 1'b1;
   end

   // read counter is word aligned
   always_comb begin
      mem_rd_o.en   = r_en_i;
      mem_rd_o.addr = r_addr_i[ADDR_W-1:RATIO_W];
   end

   // marks the cycle the RAM returns a fresh word
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         r_vld_q <= 1'b0;
      end else begin
         r_vld_q <= r_en_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (r_vld_q) begin
         r_hold_q <= mem_rdata_i;
      end
   end

   // last word stays on the output until the next accepted read
   assign r_data_o = r_vld_q ? mem_rdata_i : r_hold_q;

endmodule

//--- fifo_sync/fifo_sync.sv
/*
 * Synchronous FIFO control: narrow writes, wide reads, level counted in narrow units.
 * Drives an external dual-port RAM through the asymmetric converter.
 */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module fifo_sync #(
   parameter int W_DATA_W = `FIFO_W_DATA_W,
   parameter int R_DATA_W = `FIFO_R_DATA_W,
   parameter int ADDR_W   = `FIFO_ADDR_W
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic                w_full_o,
   input  logic                r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_empty_o,
   output logic [ADDR_W:0]     level_o,
   output fifo_pkg::mem_wr_t   mem_wr_o,
   output fifo_pkg::mem_rd_t   mem_rd_o,
   input  logic [R_DATA_W-1:0] mem_rdata_i
);

   localparam int RATIO = R_DATA_W / W_DATA_W;
   localparam logic [ADDR_W-1:0] R_STEP = ADDR_W'(RATIO);
   localparam logic [ADDR_W:0] R_INCR = {1'b0, R_STEP};
   localparam logic [ADDR_W:0] CAPACITY = {1'b1, {ADDR_W{1'b0}}};

   logic               w_en_int;
   logic               r_en_int;
   logic [ADDR_W-1:0]  w_addr_q;
   logic [ADDR_W-1:0]  r_addr_q;
   logic [ADDR_W:0]    level_q;
   logic [ADDR_W:0]    level_nxt;
   fifo_pkg::fifo_op_e op;

   // requests past the flags are dropped
   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   assign op = fifo_pkg::fifo_op_e'({r_en_int, w_en_int});

   always_comb begin
      case (op)
         fifo_pkg::OP_WRITE: level_nxt = level_q + 1'b1;
         fifo_pkg::OP_READ:  level_nxt = level_q - R_INCR;
         fifo_pkg::OP_BOTH:  level_nxt = level_q + 1'b1 - R_INCR;
         default:            level_nxt = level_q;
      endcase
   end

   // both counters in narrow units, read steps one word
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_addr_q <= '0;
         r_addr_q <= '0;
      end else begin
         if (w_en_int) begin
            w_addr_q <= w_addr_q + 1'b1;
         end
         if (r_en_int) begin
            r_addr_q <= r_addr_q + R_STEP;
         end
      end
   end

   // flags follow the next level so they change with it
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         level_q   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level_q   <= level_nxt;
         r_empty_o <= level_nxt < R_INCR;
         w_full_o  <= level_nxt == CAPACITY;
      end
   end

   assign level_o = level_q;

   asym_converter #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_conv (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .w_en_i     (w_en_int),
      .w_addr_i   (w_addr_q),
      .w_data_i   (w_data_i),
      .r_en_i     (r_en_int),
      .r_addr_i   (r_addr_q),
      .r_data_o   (r_data_o),
      .mem_wr_o   (mem_wr_o),
      .mem_rd_o   (mem_rd_o),
      .mem_rdata_i(mem_rdata_i)
   );

endmodule

//--- source/fifo_top.sv
/*
 * Top level of the asymmetric FIFO: control block plus its dual-port RAM.
 * Byte-wide writes in, word-wide reads out.
 */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module fifo_top (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      w_en_i,
   input  logic [`FIFO_W_DATA_W-1:0] w_data_i,
   output logic                      w_full_o,
   input  logic                      r_en_i,
   output logic [`FIFO_R_DATA_W-1:0] r_data_o,
   output logic                      r_empty_o,
   output logic [`FIFO_ADDR_W:0]     level_o
);

   localparam int RATIO = `FIFO_R_DATA_W / `FIFO_W_DATA_W;
   localparam int MEM_ADDR_W = `FIFO_ADDR_W - $clog2(RATIO);

   fifo_pkg::mem_wr_t         mem_wr;
   fifo_pkg::mem_rd_t         mem_rd;
   logic [`FIFO_R_DATA_W-1:0] mem_rdata;

   fifo_sync #(
      .W_DATA_W(`FIFO_W_DATA_W),
      .R_DATA_W(`FIFO_R_DATA_W),
      .ADDR_W  (`FIFO_ADDR_W)
   ) u_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .w_en_i     (w_en_i),
      .w_data_i   (w_data_i),
      .w_full_o   (w_full_o),
      .r_en_i     (r_en_i),
      .r_data_o   (r_data_o),
      .r_empty_o  (r_empty_o),
      .level_o    (level_o),
      .mem_wr_o   (mem_wr),
      .mem_rd_o   (mem_rd),
      .mem_rdata_i(mem_rdata)
   );

   dp_ram #(
      .DATA_W(`FIFO_R_DATA_W),
      .ADDR_W(MEM_ADDR_W),
      .LANES (RATIO)
   ) u_ram (
      .clk_i  (clk_i),
      .wr_i   (mem_wr),
      .rd_i   (mem_rd),
      .rdata_o(mem_rdata)
   );

endmodule

//--- verif/tb_clock_gen.sv
/*
 * Free-running testbench clock, low at time zero.
 */
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter real PERIOD_NS = 10.0
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0);
         clk_o = ~clk_o;
      end
   end

endmodule

//--- verif/fifo_chk.sv
/*
 * Concurrent assertions on the FIFO flags and fill level.
 * Bound into every fifo_sync instance at the bottom of this file.
 */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module fifo_chk #(
   parameter int ADDR_W = `FIFO_ADDR_W
) (
   input logic               clk_i,
   input logic               rst_n_i,
   input logic               full_i,
   input logic               empty_i,
   input logic [ADDR_W:0]    level_i,
   input fifo_pkg::fifo_op_e op_i
);

   localparam logic [ADDR_W:0] CAPACITY = {1'b1, {ADDR_W{1'b0}}};

   a_flags_exclusive: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !(full_i && empty_i)
   ) else $error("full and empty asserted together");

   a_level_bound: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) level_i <= CAPACITY
   ) else $error("level above capacity: %0d", level_i);

   // a lone write adds one narrow unit
   a_write_step: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (op_i == fifo_pkg::OP_WRITE) |=> (level_i == $past(level_i) + 1'b1)
   ) else $error("write did not raise level by one");

endmodule

bind fifo_sync fifo_chk #(.ADDR_W(ADDR_W)) u_chk (
   .clk_i  (clk_i),
   .rst_n_i(rst_n_i),
   .full_i (w_full_o),
   .empty_i(r_empty_o),
   .level_i(level_o),
   .op_i   (op)
);

//--- verif/fifo_tb.sv
/*
 * Testbench of the asymmetric FIFO. Replays the trace file, then runs a fill to full
 * with a drain, and a random fill whose words are packed by the testbench.
 */
`timescale 1ns/100ps
`include "fifo_defs.svh"

module fifo_tb;

   localparam int W_W = `FIFO_W_DATA_W;
   localparam int R_W = `FIFO_R_DATA_W;
   localparam int RATIO = R_W / W_W;
   localparam int CAPACITY = 1 << `FIFO_ADDR_W;
   localparam int WAIT_LIMIT = 400;
   localparam int WATCHDOG_NS = 50000;
   localparam string TRACE_FILE = "verif/fifo_trace.txt";

   logic              clk;
   logic              rst_n;
   logic              w_en;
   logic [W_W-1:0]    w_data;
   logic              w_full;
   logic              r_en;
   logic [R_W-1:0]    r_data;
   logic              r_empty;
   logic [`FIFO_ADDR_W:0] level;

   int             seed;
   int             test_errs;
   int             total_errs;
   int             tests_run;
   int             tests_failed;
   int             model_level;
   string          cur_test;
   logic [W_W-1:0] byte_q[$];

   tb_clock_gen #(.PERIOD_NS(10.0)) u_clk (.clk_o(clk));

   fifo_top uut (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .w_en_i   (w_en),
      .w_data_i (w_data),
      .w_full_o (w_full),
      .r_en_i   (r_en),
      .r_data_o (r_data),
      .r_empty_o(r_empty),
      .level_o  (level)
   );

   task automatic check_val(input string what, input logic [R_W-1:0] exp,
                            input logic [R_W-1:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
         test_errs++;
      end
   endtask

   // a dash in the trace skips the check
   task automatic compare_field(input string what, input string exp, input logic [R_W-1:0] act);
      logic [R_W-1:0] v;
      if (exp != "-") begin
         void'($sscanf(exp, "%h", v));
         check_val(what, v, act);
      end
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("test %s: ok", cur_test);
      end else begin
         $display("test %s: FAILED with %0d errors", cur_test, test_errs);
         tests_failed++;
      end
      total_errs += test_errs;
      test_errs = 0;
   endtask

   // called on a falling edge and returns on the next one
   task automatic apply(input logic w, input logic [W_W-1:0] d, input logic r);
      w_en = w;
      w_data = d;
      r_en = r;
      @(negedge clk);
   endtask

   // earliest byte lands in the low lane
   function automatic logic [R_W-1:0] pack_word();
      logic [R_W-1:0] word;
      word = '0;
      for (int k = 0; k < RATIO; k++) begin
         if (byte_q.size() > 0) begin
            word[k*W_W +: W_W] = byte_q.pop_front();
         end
      end
      return word;
   endfunction

   function automatic logic [W_W-1:0] fill_byte(input int addr);
      return W_W'(addr * 7 + 19);
   endfunction

   task automatic replay_trace();
      int fd;
      int n;
      int w;
      int r;
      string line;
      string name;
      string e_data;
      string e_lvl;
      string e_emp;
      string e_full;
      logic [W_W-1:0] d;
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) begin
         $display("could not open the trace file %s", TRACE_FILE);
         total_errs++;
         return;
      end
      cur_test = "";
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line.getc(0) == "#") begin
            continue;
         end
         n = $sscanf(line, "%s %h %h %h %s %s %s %s", name, w, d, r,
                     e_data, e_lvl, e_emp, e_full);
         if (n != 8) begin
            continue;
         end
         if (name != cur_test) begin
            if (cur_test != "") begin
               finish_test();
            end
            cur_test = name;
         end
         apply(w[0], d, r[0]);
         compare_field("r_data", e_data, r_data);
         compare_field("level", e_lvl, R_W'(level));
         compare_field("empty", e_emp, R_W'(r_empty));
         compare_field("full", e_full, R_W'(w_full));
      end
      if (cur_test != "") begin
         finish_test();
      end
      $fclose(fd);
   endtask

   task automatic fill_and_drain();
      int cnt;
      logic [W_W-1:0] b;
      logic [R_W-1:0] exp_word;
      cur_test = "fill_full";
      byte_q.delete();
      for (int i = 0; i < CAPACITY; i++) begin
         b = fill_byte(i);
         byte_q.push_back(b);
         apply(1'b1, b, 1'b0);
         check_val("level", R_W'(i + 1), R_W'(level));
         check_val("full", R_W'(i + 1 == CAPACITY), R_W'(w_full));
      end
      // one write too many is dropped
      apply(1'b1, 8'hee, 1'b0);
      check_val("level", R_W'(CAPACITY), R_W'(level));
      check_val("full", 1, R_W'(w_full));
      cnt = 0;
      while (!r_empty && cnt < WAIT_LIMIT) begin
         exp_word = pack_word();
         apply(1'b0, '0, 1'b1);
         check_val("r_data", exp_word, r_data);
         cnt++;
      end
      if (cnt >= WAIT_LIMIT) begin
         $display("timeout in %s: FIFO never went empty while draining", cur_test);
         test_errs++;
      end
      check_val("words read", R_W'(CAPACITY / RATIO), R_W'(cnt));
      check_val("level", 0, R_W'(level));
      apply(1'b0, '0, 1'b0);
      finish_test();
   endtask

   task automatic random_fill();
      int cnt;
      logic w;
      logic r;
      logic [W_W-1:0] b;
      logic [R_W-1:0] exp_word;
      cur_test = "random_fill";
      byte_q.delete();
      model_level = 0;
      cnt = 0;
      while (!w_full && cnt < WAIT_LIMIT) begin
         w = (($random(seed) & 3) != 0);
         b = W_W'($random(seed));
         if (w && model_level < CAPACITY) begin
            byte_q.push_back(b);
            model_level++;
         end
         apply(w, b, 1'b0);
         check_val("level", R_W'(model_level), R_W'(level));
         check_val("full", R_W'(model_level == CAPACITY), R_W'(w_full));
         check_val("empty", R_W'(model_level < RATIO), R_W'(r_empty));
         cnt++;
      end
      if (cnt >= WAIT_LIMIT) begin
         $display("timeout in %s: FIFO never reported full", cur_test);
         test_errs++;
      end
      cnt = 0;
      while (!r_empty && cnt < WAIT_LIMIT) begin
         r = (($random(seed) & 1) != 0);
         exp_word = '0;
         if (r && model_level >= RATIO) begin
            exp_word = pack_word();
            model_level -= RATIO;
         end
         apply(1'b0, '0, r);
         if (r) begin
            check_val("r_data", exp_word, r_data);
         end
         check_val("level", R_W'(model_level), R_W'(level));
         check_val("full", R_W'(model_level == CAPACITY), R_W'(w_full));
         check_val("empty", R_W'(model_level < RATIO), R_W'(r_empty));
         cnt++;
      end
      if (cnt >= WAIT_LIMIT) begin
         $display("timeout in %s: FIFO never went empty while draining", cur_test);
         test_errs++;
      end
      apply(1'b0, '0, 1'b0);
      finish_test();
   endtask

   initial begin
      seed = 32'h68005c24;
      rst_n = 1'b0;
      w_en = 1'b0;
      w_data = '0;
      r_en = 1'b0;
      test_errs = 0;
      total_errs = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      replay_trace();
      fill_and_drain();
      random_fill();
      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, total_errs);
      if (total_errs == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("simulation still running after %0d ns, stopped", WATCHDOG_NS);
      $display("Test failures found");
      $finish;
   end

endmodule

//--- verif/fifo_trace.txt
# name w_en w_data r_en | expected r_data level empty full, all hex
# one clock cycle per line, a dash skips that check
reset_state  0 00 0 -        00 1 0
word_pack    1 11 0 -        01 1 0
word_pack    1 22 0 -        02 1 0
word_pack    1 33 0 -        03 1 0
word_pack    1 44 0 -        04 0 0
word_pack    0 00 1 44332211 00 1 0
partial      1 a1 0 44332211 01 1 0
partial      1 a2 0 44332211 02 1 0
partial      1 a3 0 44332211 03 1 0
partial      0 00 1 44332211 03 1 0
same_cycle   1 a4 0 -        04 0 0
same_cycle   1 a5 0 -        05 0 0
same_cycle   1 a6 1 a4a3a2a1 02 1 0
flush        1 a7 0 a4a3a2a1 03 1 0
flush        1 a8 0 -        04 0 0
flush        0 00 1 a8a7a6a5 00 1 0
flush        0 00 0 a8a7a6a5 00 1 0
back_to_back 1 01 0 -        01 1 0
back_to_back 1 02 0 -        02 1 0
back_to_back 1 03 0 -        03 1 0
back_to_back 1 04 0 -        04 0 0
back_to_back 1 05 0 -        05 0 0
back_to_back 1 06 0 -        06 0 0
back_to_back 1 07 0 -        07 0 0
back_to_back 1 08 0 -        08 0 0
back_to_back 0 00 1 04030201 04 0 0
back_to_back 0 00 1 08070605 00 1 0
back_to_back 0 00 0 08070605 00 1 0

//--- flist.f
+incdir+common
common/fifo_pkg.sv
source/dp_ram.sv
fifo_sync/asym_converter.sv
fifo_sync/fifo_sync.sv
source/fifo_top.sv
verif/tb_clock_gen.sv
verif/fifo_chk.sv
verif/fifo_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fifo_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failures found

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	else \
		echo "simulation ok"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
